//--- design/csr_macros.svh
`ifndef CSR_MACROS_SVH
`define CSR_MACROS_SVH

// core sizes
`define NUM_WARPS        4
`define NUM_THREADS      4
`define UUID_BITS        8
`define WORD_BITS        32
`define REG_BITS         5
`define CSR_ADDR_BITS    12
`define CSR_OP_BITS      2
`define NUM_SCRATCH      4

// csr operations
`define CSR_OP_RW        2'd0
`define CSR_OP_RS        2'd1
`define CSR_OP_RC        2'd2

// csr address map
`define CSR_SCRATCH_BASE 12'h7C0 // 0x7C0..0x7C3
`define CSR_THREAD_ID    12'hCC0 // read-only
`define CSR_WARP_ID      12'hCC1 // read-only

`endif

//--- design/csr_pkg.sv
`include "csr_macros.svh"

package csr_pkg;

    typedef logic [`UUID_BITS-1:0]              uuid_t;      // instruction tag
    typedef logic [$clog2(`NUM_WARPS)-1:0]      wid_t;
    typedef logic [`NUM_WARPS-1:0]              warp_mask_t;
    typedef logic [`NUM_THREADS-1:0]            tmask_t;

    typedef logic [`WORD_BITS-1:0]              word_t;

    // lane 0 in the low word
    typedef logic [`NUM_THREADS*`WORD_BITS-1:0] lane_data_t;

    typedef logic [`CSR_ADDR_BITS-1:0]          csr_addr_t;
    typedef logic [`CSR_OP_BITS-1:0]            csr_op_t;
    typedef logic [`REG_BITS-1:0]               reg_t;       // destination register

endpackage

//--- design/csr_data.sv
`timescale 1ns/10ps

`include "csr_macros.svh"

module csr_data (
    input  logic                clk,
    input  logic                reset,

    input  csr_pkg::wid_t       read_wid,
    input  csr_pkg::csr_addr_t  read_addr,
    output csr_pkg::lane_data_t read_data,

    input  logic                write_enable,
    input  csr_pkg::wid_t       write_wid,
    input  csr_pkg::tmask_t     write_tmask,
    input  csr_pkg::csr_addr_t  write_addr,
    input  csr_pkg::lane_data_t write_data
);

    localparam int SIDX_BITS = $clog2(`NUM_SCRATCH);

    csr_pkg::word_t scratch [`NUM_WARPS][`NUM_SCRATCH][`NUM_THREADS];

    logic [SIDX_BITS-1:0] read_idx;
    logic [SIDX_BITS-1:0] write_idx;
    logic                 read_scratch;
    logic                 write_scratch;

    function automatic logic is_scratch(input csr_pkg::csr_addr_t addr);
        return (addr >= `CSR_SCRATCH_BASE) && (addr < `CSR_SCRATCH_BASE + `NUM_SCRATCH);
    endfunction

    assign read_scratch  = is_scratch(read_addr);
    assign write_scratch = is_scratch(write_addr);
    assign read_idx      = SIDX_BITS'(read_addr - `CSR_SCRATCH_BASE);
    assign write_idx     = SIDX_BITS'(write_addr - `CSR_SCRATCH_BASE);

    // read decode, one word per lane
    always_comb begin
        read_data = '0;
        for (int i = 0; i < `NUM_THREADS; i++) begin
            if (read_scratch) begin
                read_data[i*`WORD_BITS +: `WORD_BITS] = scratch[read_wid][read_idx][i];
            end else if (read_addr == `CSR_THREAD_ID) begin
                read_data[i*`WORD_BITS +: `WORD_BITS] = csr_pkg::word_t'(i); // lane number
            end else if (read_addr == `CSR_WARP_ID) begin
                read_data[i*`WORD_BITS +: `WORD_BITS] = csr_pkg::word_t'(read_wid);
            end
        end
    end

    // masked write, scratch only
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int w = 0; w < `NUM_WARPS; w++) begin
                for (int s = 0; s < `NUM_SCRATCH; s++) begin
                    for (int t = 0; t < `NUM_THREADS; t++) begin
                        scratch[w][s][t] <= '0;
                    end
                end
            end
        end else if (write_enable && write_scratch) begin
            for (int t = 0; t < `NUM_THREADS; t++) begin
                if (write_tmask[t]) begin
                    scratch[write_wid][write_idx][t] <= write_data[t*`WORD_BITS +: `WORD_BITS];
                end
            end
        end
    end

endmodule

//--- design/skid_buffer.sv
`timescale 1ns/10ps

module skid_buffer #(
    parameter int DATAW = 8
) (
    input  logic             clk,
    input  logic             reset,

    input  logic             valid_in,
    output logic             ready_in,
    input  logic [DATAW-1:0] data_in,

    output logic             valid_out,
    input  logic             ready_out,
    output logic [DATAW-1:0] data_out
);

    logic             skid_valid;
    logic [DATAW-1:0] skid_data;
    logic             load_out;

    assign load_out = ready_out || !valid_out; // output stage free this cycle
    assign ready_in = !skid_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (load_out) begin
            valid_out  <= skid_valid || valid_in;
            skid_valid <= 1'b0;
        end else if (valid_in && ready_in) begin
            skid_valid <= 1'b1; // output stalled, park it
        end
    end

    always_ff @(posedge clk) begin
        if (load_out) begin
            data_out <= skid_valid ? skid_data : data_in; // oldest first
        end
        if (!load_out && valid_in && ready_in) begin
            skid_data <= data_in;
        end
    end

endmodule

//--- design/csr_unit.sv
`timescale 1ns/10ps

`include "csr_macros.svh"

module csr_unit (
    input  logic                 clk,
    input  logic                 reset,

    input  logic                 req_valid,
    output logic                 req_ready,
    input  csr_pkg::uuid_t       req_uuid,
    input  csr_pkg::wid_t        req_wid,
    input  csr_pkg::tmask_t      req_tmask,
    input  csr_pkg::word_t       req_pc,
    input  csr_pkg::csr_op_t     req_op,
    input  csr_pkg::csr_addr_t   req_addr,
    input  logic                 req_use_imm,
    input  logic [4:0]           req_imm,
    input  csr_pkg::lane_data_t  req_rs1_data,
    input  csr_pkg::reg_t        req_rd,
    input  logic                 req_wb,

    output logic                 commit_valid,
    input  logic                 commit_ready,
    output csr_pkg::uuid_t       commit_uuid,
    output csr_pkg::wid_t        commit_wid,
    output csr_pkg::tmask_t      commit_tmask,
    output csr_pkg::word_t       commit_pc,
    output csr_pkg::reg_t        commit_rd,
    output logic                 commit_wb,
    output csr_pkg::lane_data_t  commit_data,

    input  csr_pkg::warp_mask_t  fpu_pending,
    output csr_pkg::warp_mask_t  req_pending
);

    localparam int DATAW = $bits(csr_pkg::uuid_t) + $bits(csr_pkg::wid_t)
                         + $bits(csr_pkg::tmask_t) + $bits(csr_pkg::word_t)
                         + $bits(csr_pkg::reg_t) + 2 + $bits(csr_pkg::csr_addr_t)
                         + 2 * $bits(csr_pkg::lane_data_t);

    csr_pkg::lane_data_t src_data;
    csr_pkg::lane_data_t read_data;
    csr_pkg::lane_data_t old_data;
    csr_pkg::lane_data_t new_data;
    logic                req_we;

    csr_pkg::lane_data_t commit_new;
    csr_pkg::csr_addr_t  commit_addr;
    logic                commit_we;

    logic                commit_fire;
    logic                write_enable;
    logic                fwd_hit;
    logic                stall;
    logic                buf_ready;
    logic [DATAW-1:0]    buf_out;

    assign commit_fire  = commit_valid && commit_ready;
    assign write_enable = commit_fire && commit_we;

    csr_data csr_data_i (
        .clk          (clk),
        .reset        (reset),
        .read_wid     (req_wid),
        .read_addr    (req_addr),
        .read_data    (read_data),
        .write_enable (write_enable),
        .write_wid    (commit_wid),
        .write_tmask  (commit_tmask),
        .write_addr   (commit_addr),
        .write_data   (commit_new)
    );

    assign src_data = req_use_imm ? {`NUM_THREADS{csr_pkg::word_t'(req_imm)}} : req_rs1_data;

    // commit writing the csr we read this cycle
    assign fwd_hit = write_enable && (commit_wid == req_wid) && (commit_addr == req_addr)
                  && (commit_addr >= `CSR_SCRATCH_BASE)
                  && (commit_addr < `CSR_SCRATCH_BASE + `NUM_SCRATCH);

    always_comb begin
        for (int i = 0; i < `NUM_THREADS; i++) begin
            old_data[i*`WORD_BITS +: `WORD_BITS] = (fwd_hit && commit_tmask[i])
                ? commit_new[i*`WORD_BITS +: `WORD_BITS]
                : read_data[i*`WORD_BITS +: `WORD_BITS];
        end
    end

    always_comb begin
        req_we = |src_data; // rs/rc with zero source is a pure read
        case (req_op)
            `CSR_OP_RW: begin
                new_data = src_data;
                req_we   = 1'b1;
            end
            `CSR_OP_RS: new_data = old_data | src_data;
            default:    new_data = old_data & ~src_data; // rc
        endcase
    end

    // fpu hold and per-warp ordering
    assign stall = fpu_pending[req_wid]
                || (req_pending[req_wid] && !(commit_fire && commit_wid == req_wid));

    assign req_ready = buf_ready && !stall;

    skid_buffer #(
        .DATAW (DATAW)
    ) rsp_buf (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (req_valid && !stall),
        .ready_in  (buf_ready),
        .data_in   ({req_uuid, req_wid, req_tmask, req_pc, req_rd, req_wb,
                     req_we, req_addr, old_data, new_data}),
        .valid_out (commit_valid),
        .ready_out (commit_ready),
        .data_out  (buf_out)
    );

    assign {commit_uuid, commit_wid, commit_tmask, commit_pc, commit_rd, commit_wb,
            commit_we, commit_addr, commit_data, commit_new} = buf_out;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_pending <= '0;
        end else begin
            if (commit_fire) begin
                req_pending[commit_wid] <= 1'b0;
            end
            if (req_valid && req_ready) begin
                req_pending[req_wid] <= 1'b1; // new issue wins over same-warp commit
            end
        end
    end

endmodule

//--- tb/csr_clock_gen.sv
`timescale 1ns/10ps

module csr_clock_gen (
    output logic clk
);

    initial clk = 1'b0;

    always #2 clk = ~clk; // 4 ns period

endmodule

//--- tb/csr_properties.sv
`timescale 1ns/10ps

module csr_properties (
    input logic                clk,
    input logic                reset,
    input logic                req_valid,
    input logic                req_ready,
    input csr_pkg::wid_t       req_wid,
    input logic                commit_valid,
    input logic                commit_ready,
    input csr_pkg::uuid_t      commit_uuid,
    input csr_pkg::wid_t       commit_wid,
    input csr_pkg::tmask_t     commit_tmask,
    input csr_pkg::word_t      commit_pc,
    input csr_pkg::reg_t       commit_rd,
    input logic                commit_wb,
    input csr_pkg::lane_data_t commit_data,
    input csr_pkg::warp_mask_t fpu_pending,
    input csr_pkg::warp_mask_t req_pending
);

    commit_idle_after_reset: assert property (@(posedge clk) reset |=> !commit_valid)
        else $error("commit_valid high right after reset");

    commit_held: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit_uuid)
            && $stable(commit_wid) && $stable(commit_tmask) && $stable(commit_pc)
            && $stable(commit_rd) && $stable(commit_wb) && $stable(commit_data))
        else $error("commit fields changed under back-pressure");

    no_accept_on_fpu: assert property (@(posedge clk) disable iff (reset)
        req_valid && req_ready |-> !fpu_pending[req_wid])
        else $error("request accepted while fpu_pending set");

    commit_was_pending: assert property (@(posedge clk) disable iff (reset)
        commit_valid && commit_ready |-> req_pending[commit_wid])
        else $error("commit from a warp without pending bit");

endmodule

bind csr_unit csr_properties props_i (.*);

//--- tb/csr_tb.sv
`timescale 1ns/10ps

`include "csr_macros.svh"

module csr_tb;

    logic clk, reset, req_valid, req_ready, req_use_imm, req_wb, commit_valid, commit_ready;
    logic [4:0] req_imm;
    logic commit_wb;
    csr_pkg::uuid_t req_uuid, commit_uuid;
    csr_pkg::wid_t req_wid, commit_wid;
    csr_pkg::tmask_t req_tmask, commit_tmask;
    csr_pkg::word_t req_pc, commit_pc;
    csr_pkg::csr_op_t req_op;
    csr_pkg::csr_addr_t req_addr;
    csr_pkg::lane_data_t req_rs1_data, commit_data;
    csr_pkg::reg_t req_rd, commit_rd;
    csr_pkg::warp_mask_t fpu_pending, req_pending;

    logic [31:0] col [16];
    logic [31:0] f_test [64], f_wid [64], f_tmask [64], f_op [64], f_imm [64];
    logic [31:0] f_use_imm [64], f_addr [64], f_fpu [64];
    csr_pkg::lane_data_t f_rs1 [64], f_exp [64];
    int num_lines = 0, done_count = 0, errors = 0, checks = 0;
    int test_errors = 0; // error count when the current test began
    int exp_q [$];
    integer seed = 85;

    csr_clock_gen clk_gen (.clk(clk));

    csr_unit UUT (.*);

    task automatic check_data(input string name, input csr_pkg::lane_data_t act,
                              input csr_pkg::lane_data_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_mask(input string name, input csr_pkg::warp_mask_t act,
                              input csr_pkg::warp_mask_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_uuid(input csr_pkg::uuid_t act, input csr_pkg::uuid_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: commit_uuid expected %h, got %h", $time, exp, act);
        end
    endtask

    task automatic check_wid(input string name, input csr_pkg::wid_t act,
                             input csr_pkg::wid_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_tmask(input string name, input csr_pkg::tmask_t act,
                               input csr_pkg::tmask_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_word(input string name, input csr_pkg::word_t act,
                              input csr_pkg::word_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_reg(input string name, input csr_pkg::reg_t act,
                             input csr_pkg::reg_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic act, input logic exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error at %0t ns: %s expected %b, got %b", $time, name, exp, act);
        end
    endtask

    // called right after a rising edge, returns at the acceptance edge
    task automatic send_request(input int i);
        int held;
        held = 0;
        req_valid    <= 1'b1;
        req_uuid     <= csr_pkg::uuid_t'(i);
        req_wid      <= csr_pkg::wid_t'(f_wid[i]);
        req_tmask    <= csr_pkg::tmask_t'(f_tmask[i]);
        req_pc       <= 32'h1000 + i * 4;
        req_op       <= csr_pkg::csr_op_t'(f_op[i]);
        req_addr     <= csr_pkg::csr_addr_t'(f_addr[i]);
        req_use_imm  <= f_use_imm[i][0];
        req_imm      <= f_imm[i][4:0];
        req_rs1_data <= f_rs1[i];
        req_rd       <= csr_pkg::reg_t'(i);
        req_wb       <= i[0];
        if (f_fpu[i] != 0) fpu_pending[f_wid[i]] <= 1'b1;
        forever begin
            @(negedge clk);
            if (held < f_fpu[i]) begin
                if (req_ready) begin
                    errors++;
                    $display("line %0d could be accepted while its warp had fpu_pending set", i);
                end
                held++;
                @(posedge clk);
                if (held == f_fpu[i]) fpu_pending <= '0; // release the hold
            end else if (req_ready) begin
                break;
            end else begin
                @(posedge clk);
            end
        end
        exp_q.push_back(i);
        @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (!reset) commit_ready <= ($random(seed) & 3) != 0; // ready 3 cycles in 4
    end

    always @(negedge clk) begin : commit_check
        int idx;
        csr_pkg::warp_mask_t wbit;
        if (!reset && commit_valid && commit_ready) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("a commit came out with no request outstanding");
            end else begin
                idx = exp_q.pop_front();
                wbit = csr_pkg::warp_mask_t'(1) << f_wid[idx];
                check_uuid(commit_uuid, csr_pkg::uuid_t'(idx));
                check_wid("commit_wid", commit_wid, csr_pkg::wid_t'(f_wid[idx]));
                check_tmask("commit_tmask", commit_tmask, csr_pkg::tmask_t'(f_tmask[idx]));
                check_word("commit_pc", commit_pc, 32'h1000 + idx * 4);
                check_reg("commit_rd", commit_rd, csr_pkg::reg_t'(idx));
                check_bit("commit_wb", commit_wb, idx[0]);
                check_data("commit_data", commit_data, f_exp[idx]);
                check_mask("req_pending", req_pending & wbit, wbit);
                done_count++;
                if (idx == num_lines - 1 || f_test[idx + 1] != f_test[idx]) begin
                    $display("test %0d: %s", f_test[idx],
                             (errors == test_errors) ? "passed" : "failed");
                    test_errors = errors;
                end
            end
        end
    end

    initial begin : watchdog
        wait (num_lines > 0);
        repeat (num_lines * 40 + 10) @(posedge clk);
        $display("timeout: %0d of %0d commits seen", done_count, num_lines);
        $display("Something failed");
        $finish;
    end

    initial begin : main
        int fd;
        int r;
        string line;
        req_valid = 0;
        req_uuid = '0;
        req_wid = '0;
        req_tmask = '0;
        req_pc = '0;
        req_op = '0;
        req_addr = '0;
        req_use_imm = 0;
        req_imm = '0;
        req_rs1_data = '0;
        req_rd = '0;
        req_wb = 1'b1;
        commit_ready = 0;
        fpu_pending = '0;
        reset = 1;
        fd = $fopen("tb/csr_input.txt", "r");
        if (fd == 0) begin
            $display("could not open tb/csr_input.txt");
            $display("Something failed");
            $finish;
        end
        while (!$feof(fd)) begin
            r = $fgets(line, fd);
            if (r == 0 || line.len() < 2 || line.getc(0) == 8'h23) continue; // skip comments
            r = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        col[0], col[1], col[2], col[3], col[4], col[5], col[6], col[7],
                        col[8], col[9], col[10], col[11], col[12], col[13], col[14], col[15]);
            if (r != 16) continue;
            f_test[num_lines] = col[0];
            f_wid[num_lines] = col[1];
            f_tmask[num_lines] = col[2];
            f_op[num_lines] = col[3];
            f_use_imm[num_lines] = col[4];
            f_imm[num_lines] = col[5];
            f_addr[num_lines] = col[6];
            f_rs1[num_lines] = {col[10], col[9], col[8], col[7]}; // lane 0 low
            f_exp[num_lines] = {col[14], col[13], col[12], col[11]};
            f_fpu[num_lines] = col[15];
            num_lines++;
        end
        $fclose(fd);
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        for (int i = 0; i < num_lines; i++) send_request(i);
        req_valid <= 1'b0;
        wait (done_count == num_lines);
        repeat (3) @(posedge clk);
        check_mask("req_pending", req_pending, '0);
        $display("%0d requests, %0d checks, %0d errors", num_lines, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- tb/csr_input.txt
# test wid tmask op use_imm imm addr rs1_0 rs1_1 rs1_2 rs1_3 exp_0 exp_1 exp_2 exp_3 fpu
# all hex, op 0=rw 1=rs 2=rc, fpu = cycles the warp is held by fpu_pending
1 0 f 0 0 0 7c0 11 22 33 44 0 0 0 0 0
1 0 f 1 0 0 7c0 0 0 0 0 11 22 33 44 0
2 1 f 0 0 0 7c1 f0 f0 f0 f0 0 0 0 0 0
2 1 f 1 0 0 7c1 0f 01 100 0 f0 f0 f0 f0 0
2 1 f 2 1 3 7c1 0 0 0 0 ff f1 1f0 f0 0
2 1 f 1 1 4 7c1 0 0 0 0 fc f0 1f0 f0 0
2 1 f 2 0 0 7c1 0 0 0 0 fc f4 1f4 f4 0
2 1 f 1 0 0 7c1 0 0 0 0 fc f4 1f4 f4 0
3 2 f 0 0 0 7c2 a0 a1 a2 a3 0 0 0 0 0
3 2 5 0 0 0 7c2 b0 b1 b2 b3 a0 a1 a2 a3 0
3 2 f 1 0 0 7c2 0 0 0 0 b0 a1 b2 a3 0
4 3 f 1 0 0 cc0 0 0 0 0 0 1 2 3 0
4 3 f 0 0 0 cc1 55 55 55 55 3 3 3 3 0
4 3 f 0 0 0 cc0 66 66 66 66 0 1 2 3 0
4 3 f 1 0 0 cc1 0 0 0 0 3 3 3 3 0
4 3 f 0 0 0 123 77 77 77 77 0 0 0 0 0
4 3 f 1 0 0 123 0 0 0 0 0 0 0 0 0
5 0 f 0 1 1 7c3 0 0 0 0 0 0 0 0 0
5 0 f 1 1 2 7c3 0 0 0 0 1 1 1 1 0
5 0 f 1 1 4 7c3 0 0 0 0 3 3 3 3 0
5 0 f 2 1 1 7c3 0 0 0 0 7 7 7 7 0
5 0 f 0 0 0 7c3 10 20 30 40 6 6 6 6 0
5 0 f 1 0 0 7c3 1 1 1 1 10 20 30 40 0
5 0 f 2 0 0 7c3 0 0 0 0 11 21 31 41 0
6 1 f 1 0 0 7c1 0 0 0 0 fc f4 1f4 f4 5
6 2 3 0 1 1f 7c2 0 0 0 0 b0 a1 b2 a3 3
6 2 f 1 0 0 7c2 0 0 0 0 1f 1f b2 a3 0

//--- all.f
+incdir+design
design/csr_pkg.sv
design/csr_data.sv
design/skid_buffer.sv
design/csr_unit.sv
tb/csr_clock_gen.sv
tb/csr_properties.sv
tb/csr_tb.sv

//--- Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --assert --timing -Wno-fatal -f all.f --top-module csr_tb -o csr_sim
	./obj_dir/csr_sim > $(LOG) 2>&1 || echo "Something failed" >> $(LOG)
	@cat $(LOG)
	@if grep -q "Something failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
